// File: source/ama_riscv_pkg.sv
package ama_riscv_pkg;

// register file geometry
localparam int RF_ADDR_W = 5;
localparam int RF_NUM_REGS = 1 << RF_ADDR_W;
localparam int XLEN = 32;

typedef logic [RF_ADDR_W-1:0] rf_addr_t;
typedef logic [XLEN-1:0] data_t;

localparam rf_addr_t RF_X0_ZERO = '0;

// ALU operand sources
typedef enum logic [1:0] {
    ALU_A_SEL_RS1 = 2'd0,
    ALU_A_SEL_PC  = 2'd1,
    ALU_A_SEL_FWD = 2'd2
} alu_a_sel_t;

typedef enum logic [1:0] {
    ALU_B_SEL_RS2 = 2'd0,
    ALU_B_SEL_IMM = 2'd1,
    ALU_B_SEL_FWD = 2'd2
} alu_b_sel_t;

// bit 1 picks the pair value, bit 0 picks wbk over mem
typedef enum logic [1:0] {
    FWD_MEM_RD  = 2'b00,
    FWD_WBK_RD  = 2'b01,
    FWD_MEM_RDP = 2'b10,
    FWD_WBK_RDP = 2'b11
} fwd_be_t;

typedef struct packed {
    logic to_dec;
    logic to_exe;
} hazard_be_t;

// decoded instruction as it moves down the pipe
typedef struct packed {
    logic       valid;
    rf_addr_t   rs1;
    rf_addr_t   rs2;
    rf_addr_t   rd;
    logic       rd_we;
    logic       rdp_we;
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    logic       store;
    logic       branch;
    logic       load;
    data_t      result;
    data_t      result_p;
} inst_ctrl_t;

// register write of the instruction sitting in mem or wbk
typedef struct packed {
    rf_addr_t rd;
    logic     rd_we;
    logic     rdp_we;
    data_t    rd_data;
    data_t    rdp_data;
} stage_wr_t;

typedef struct packed {
    logic       valid;
    data_t      rs1_val;
    data_t      rs2_val;
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
} exe_opnd_t;

// empty slot pushed into the pipe on a stall
localparam inst_ctrl_t INST_BUBBLE = '0;

// pair register is the index with bit 0 flipped
function automatic rf_addr_t get_rdp(input rf_addr_t rd);
    return {rd[RF_ADDR_W-1:1], ~rd[0]};
endfunction

endpackage

// File: source/ama_riscv_operand_forwarding.sv
`timescale 1ns/1ps

module ama_riscv_operand_forwarding (
    input  logic store_inst_dec,
    input  logic branch_inst_dec,
    input  logic store_inst_exe,
    input  logic branch_inst_exe,
    input  logic load_inst_mem,
    input  ama_riscv_pkg::rf_addr_t rs1_dec,
    input  ama_riscv_pkg::rf_addr_t rs2_dec,
    input  ama_riscv_pkg::rf_addr_t rs1_exe,
    input  ama_riscv_pkg::rf_addr_t rs2_exe,
    input  ama_riscv_pkg::rf_addr_t rd_mem,
    input  ama_riscv_pkg::rf_addr_t rd_wbk,
    input  logic rd_we_mem,
    input  logic rd_we_wbk,
    input  logic rdp_we_mem,
    input  logic rdp_we_wbk,
    input  ama_riscv_pkg::alu_a_sel_t alu_a_sel_dec,
    input  ama_riscv_pkg::alu_b_sel_t alu_b_sel_dec,
    input  ama_riscv_pkg::alu_a_sel_t alu_a_sel_exe,
    input  ama_riscv_pkg::alu_b_sel_t alu_b_sel_exe,
    output ama_riscv_pkg::fwd_be_t fwd_be_rs1_dec,
    output ama_riscv_pkg::fwd_be_t fwd_be_rs2_dec,
    output ama_riscv_pkg::fwd_be_t fwd_be_rs1_exe,
    output ama_riscv_pkg::fwd_be_t fwd_be_rs2_exe,
    output ama_riscv_pkg::alu_a_sel_t alu_a_sel_fwd,
    output ama_riscv_pkg::alu_b_sel_t alu_b_sel_fwd,
    output logic bc_a_sel_fwd,
    output logic bcs_b_sel_fwd,
    output logic rf_a_sel_fwd,
    output logic rf_b_sel_fwd,
    output ama_riscv_pkg::hazard_be_t hazard_be
);

// where a source register is found among the in-flight writes
typedef struct packed {
    logic in_mem_rd;
    logic in_mem_rdp;
    logic in_wbk_rd;
    logic in_wbk_rdp;
    logic in_mem;
    logic in_wbk;
    logic on_rdp;
    logic has;
} dep_t;

ama_riscv_pkg::rf_addr_t rdp_mem;
ama_riscv_pkg::rf_addr_t rdp_wbk;

assign rdp_mem = ama_riscv_pkg::get_rdp(rd_mem);
assign rdp_wbk = ama_riscv_pkg::get_rdp(rd_wbk);

function automatic dep_t find_dep(input ama_riscv_pkg::rf_addr_t rs);
    dep_t d;
    logic nz;
    nz = (rs != ama_riscv_pkg::RF_X0_ZERO);
    d.in_mem_rd  = nz && rd_we_mem && (rs == rd_mem);
    d.in_mem_rdp = nz && rdp_we_mem && (rs == rdp_mem);
    d.in_wbk_rd  = nz && rd_we_wbk && (rs == rd_wbk);
    d.in_wbk_rdp = nz && rdp_we_wbk && (rs == rdp_wbk);
    d.in_mem = d.in_mem_rd || d.in_mem_rdp;
    d.in_wbk = d.in_wbk_rd || d.in_wbk_rdp;
    // mem is the younger write, so its rd/rdp choice wins
    d.on_rdp = d.in_mem ? d.in_mem_rdp : d.in_wbk_rdp;
    d.has = d.in_mem || d.in_wbk;
    return d;
endfunction

dep_t d_rs1_dec;
dep_t d_rs2_dec;
dep_t d_rs1_exe;
dep_t d_rs2_exe;

always_comb begin
    d_rs1_dec = find_dep(rs1_dec);
    d_rs2_dec = find_dep(rs2_dec);
    d_rs1_exe = find_dep(rs1_exe);
    d_rs2_exe = find_dep(rs2_exe);
end

// low bit set means take it from wbk
assign fwd_be_rs1_dec = ama_riscv_pkg::fwd_be_t'({d_rs1_dec.on_rdp, !d_rs1_dec.in_mem});
assign fwd_be_rs2_dec = ama_riscv_pkg::fwd_be_t'({d_rs2_dec.on_rdp, !d_rs2_dec.in_mem});
assign fwd_be_rs1_exe = ama_riscv_pkg::fwd_be_t'({d_rs1_exe.on_rdp, !d_rs1_exe.in_mem});
assign fwd_be_rs2_exe = ama_riscv_pkg::fwd_be_t'({d_rs2_exe.on_rdp, !d_rs2_exe.in_mem});

// ALU only switches to forwarded data when it reads the register
assign alu_a_sel_fwd =
    (d_rs1_exe.has && (alu_a_sel_exe == ama_riscv_pkg::ALU_A_SEL_RS1)) ?
    ama_riscv_pkg::ALU_A_SEL_FWD : alu_a_sel_exe;

assign alu_b_sel_fwd =
    (d_rs2_exe.has && (alu_b_sel_exe == ama_riscv_pkg::ALU_B_SEL_RS2)) ?
    ama_riscv_pkg::ALU_B_SEL_FWD : alu_b_sel_exe;

// branch compare uses both sources, store data uses rs2
assign bc_a_sel_fwd = d_rs1_exe.has && branch_inst_exe;
assign bcs_b_sel_fwd = d_rs2_exe.has && (store_inst_exe || branch_inst_exe);

// replace the register file read in dec
assign rf_a_sel_fwd = d_rs1_dec.has &&
    ((alu_a_sel_dec == ama_riscv_pkg::ALU_A_SEL_RS1) || branch_inst_dec);

assign rf_b_sel_fwd = d_rs2_dec.has &&
    ((alu_b_sel_dec == ama_riscv_pkg::ALU_B_SEL_RS2) || branch_inst_dec ||
     store_inst_dec);

// load data is not ready until wbk
assign hazard_be.to_dec = load_inst_mem && (d_rs1_dec.in_mem || d_rs2_dec.in_mem);
assign hazard_be.to_exe = load_inst_mem && (d_rs1_exe.in_mem || d_rs2_exe.in_mem);

endmodule

// File: source/ama_riscv_reg_file.sv
`timescale 1ns/1ps

module ama_riscv_reg_file (
    input  logic clk,
    input  logic rst_n,
    input  ama_riscv_pkg::rf_addr_t rs1,
    input  ama_riscv_pkg::rf_addr_t rs2,
    input  ama_riscv_pkg::stage_wr_t wr,
    output ama_riscv_pkg::data_t rs1_data,
    output ama_riscv_pkg::data_t rs2_data
);

ama_riscv_pkg::data_t regs [ama_riscv_pkg::RF_NUM_REGS];
ama_riscv_pkg::rf_addr_t wr_rdp;

assign wr_rdp = ama_riscv_pkg::get_rdp(wr.rd);

// rd and its pair never alias so both can land in one cycle
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < ama_riscv_pkg::RF_NUM_REGS; i++) begin
            regs[i] <= '0;
        end
    end else begin
        if (wr.rd_we && (wr.rd != ama_riscv_pkg::RF_X0_ZERO)) begin
            regs[wr.rd] <= wr.rd_data;
        end
        if (wr.rdp_we && (wr_rdp != ama_riscv_pkg::RF_X0_ZERO)) begin
            regs[wr_rdp] <= wr.rdp_data;
        end
    end
end

// async read returns the old value during a write
assign rs1_data = (rs1 == ama_riscv_pkg::RF_X0_ZERO) ? '0 : regs[rs1];
assign rs2_data = (rs2 == ama_riscv_pkg::RF_X0_ZERO) ? '0 : regs[rs2];

endmodule

// File: source/ama_riscv_fwd_data_mux.sv
`timescale 1ns/1ps

module ama_riscv_fwd_data_mux (
    input  ama_riscv_pkg::fwd_be_t fwd_be,
    input  ama_riscv_pkg::stage_wr_t mem_wr,
    input  ama_riscv_pkg::stage_wr_t wbk_wr,
    output ama_riscv_pkg::data_t opnd
);

// match already resolved by the forwarding unit so only data is steered here
always_comb begin
    case (fwd_be)
        ama_riscv_pkg::FWD_MEM_RD: begin
            opnd = mem_wr.rd_data;
        end
        ama_riscv_pkg::FWD_WBK_RD: begin
            opnd = wbk_wr.rd_data;
        end
        ama_riscv_pkg::FWD_MEM_RDP: begin
            opnd = mem_wr.rdp_data;
        end
        ama_riscv_pkg::FWD_WBK_RDP: begin
            opnd = wbk_wr.rdp_data;
        end
        default: begin
            opnd = '0;
        end
    endcase
end

endmodule

// File: source/ama_riscv_pipe_ctrl.sv
`timescale 1ns/1ps

module ama_riscv_pipe_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  ama_riscv_pkg::inst_ctrl_t dec_in,
    input  ama_riscv_pkg::data_t dec_rs1_val,
    input  ama_riscv_pkg::data_t dec_rs2_val,
    input  ama_riscv_pkg::hazard_be_t hazard_be,
    output ama_riscv_pkg::inst_ctrl_t exe_inst,
    output ama_riscv_pkg::inst_ctrl_t mem_inst,
    output ama_riscv_pkg::inst_ctrl_t wbk_inst,
    output ama_riscv_pkg::data_t exe_rs1_val,
    output ama_riscv_pkg::data_t exe_rs2_val
);

ama_riscv_pkg::inst_ctrl_t dec_to_exe;
logic exe_hold;

// a load in mem with an exe dependent freezes dec and exe
assign exe_hold = hazard_be.to_exe;

// invalid slots are cleared so stale indices never match
assign dec_to_exe = (hazard_be.to_dec || !dec_in.valid) ?
    ama_riscv_pkg::INST_BUBBLE : dec_in;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        exe_inst <= ama_riscv_pkg::INST_BUBBLE;
        mem_inst <= ama_riscv_pkg::INST_BUBBLE;
        wbk_inst <= ama_riscv_pkg::INST_BUBBLE;
    end else begin
        // the load always moves on, so any stall is one cycle
        wbk_inst <= mem_inst;
        if (exe_hold) begin
            mem_inst <= ama_riscv_pkg::INST_BUBBLE;
        end else begin
            mem_inst <= exe_inst;
            exe_inst <= dec_to_exe;
        end
    end
end

// operand values read in dec ride along with the exe slot
always_ff @(posedge clk) begin
    if (!exe_hold) begin
        exe_rs1_val <= dec_rs1_val;
        exe_rs2_val <= dec_rs2_val;
    end
end

endmodule

// File: source/ama_riscv_operand_stage.sv
`timescale 1ns/1ps

module ama_riscv_operand_stage (
    input  logic clk,
    input  logic rst_n,
    input  ama_riscv_pkg::inst_ctrl_t dec_inst,
    output logic dec_stall,
    output ama_riscv_pkg::exe_opnd_t exe_opnd,
    output ama_riscv_pkg::stage_wr_t wbk_wr
);

ama_riscv_pkg::inst_ctrl_t exe_inst;
ama_riscv_pkg::inst_ctrl_t mem_inst;
ama_riscv_pkg::inst_ctrl_t wbk_inst;
ama_riscv_pkg::stage_wr_t mem_wr;
ama_riscv_pkg::hazard_be_t hazard_be;
ama_riscv_pkg::rf_addr_t rs1_dec;
ama_riscv_pkg::rf_addr_t rs2_dec;
ama_riscv_pkg::data_t rf_rs1_data;
ama_riscv_pkg::data_t rf_rs2_data;
ama_riscv_pkg::data_t dec_fwd_rs1;
ama_riscv_pkg::data_t dec_fwd_rs2;
ama_riscv_pkg::data_t exe_fwd_rs1;
ama_riscv_pkg::data_t exe_fwd_rs2;
ama_riscv_pkg::data_t dec_rs1_val;
ama_riscv_pkg::data_t dec_rs2_val;
ama_riscv_pkg::data_t exe_rs1_val;
ama_riscv_pkg::data_t exe_rs2_val;
ama_riscv_pkg::fwd_be_t fwd_be_rs1_dec;
ama_riscv_pkg::fwd_be_t fwd_be_rs2_dec;
ama_riscv_pkg::fwd_be_t fwd_be_rs1_exe;
ama_riscv_pkg::fwd_be_t fwd_be_rs2_exe;
ama_riscv_pkg::alu_a_sel_t alu_a_sel_fwd;
ama_riscv_pkg::alu_b_sel_t alu_b_sel_fwd;
logic bc_a_sel_fwd;
logic bcs_b_sel_fwd;
logic rf_a_sel_fwd;
logic rf_b_sel_fwd;

// a bubble in dec must not look like a dependent
assign rs1_dec = dec_inst.valid ? dec_inst.rs1 : ama_riscv_pkg::RF_X0_ZERO;
assign rs2_dec = dec_inst.valid ? dec_inst.rs2 : ama_riscv_pkg::RF_X0_ZERO;

assign dec_stall = hazard_be.to_dec || hazard_be.to_exe;

always_comb begin
    // load data only exists from wbk on
    mem_wr.rd       = mem_inst.rd;
    mem_wr.rd_we    = mem_inst.valid && mem_inst.rd_we && !mem_inst.load;
    mem_wr.rdp_we   = mem_inst.valid && mem_inst.rdp_we && !mem_inst.load;
    mem_wr.rd_data  = mem_inst.result;
    mem_wr.rdp_data = mem_inst.result_p;

    wbk_wr.rd       = wbk_inst.rd;
    wbk_wr.rd_we    = wbk_inst.valid && wbk_inst.rd_we;
    wbk_wr.rdp_we   = wbk_inst.valid && wbk_inst.rdp_we;
    wbk_wr.rd_data  = wbk_inst.result;
    wbk_wr.rdp_data = wbk_inst.result_p;
end

ama_riscv_reg_file reg_file_i (
    .clk(clk),
    .rst_n(rst_n),
    .rs1(dec_inst.rs1),
    .rs2(dec_inst.rs2),
    .wr(wbk_wr),
    .rs1_data(rf_rs1_data),
    .rs2_data(rf_rs2_data)
);

ama_riscv_operand_forwarding fwd_i (
    .store_inst_dec(dec_inst.store),
    .branch_inst_dec(dec_inst.branch),
    .store_inst_exe(exe_inst.store),
    .branch_inst_exe(exe_inst.branch),
    .load_inst_mem(mem_inst.valid && mem_inst.load),
    .rs1_dec(rs1_dec),
    .rs2_dec(rs2_dec),
    .rs1_exe(exe_inst.rs1),
    .rs2_exe(exe_inst.rs2),
    .rd_mem(mem_inst.rd),
    .rd_wbk(wbk_wr.rd),
    // a load in mem still flags its target so the hazard can catch it
    .rd_we_mem(mem_inst.valid && mem_inst.rd_we),
    .rd_we_wbk(wbk_wr.rd_we),
    .rdp_we_mem(mem_inst.valid && mem_inst.rdp_we),
    .rdp_we_wbk(wbk_wr.rdp_we),
    .alu_a_sel_dec(dec_inst.alu_a_sel),
    .alu_b_sel_dec(dec_inst.alu_b_sel),
    .alu_a_sel_exe(exe_inst.alu_a_sel),
    .alu_b_sel_exe(exe_inst.alu_b_sel),
    .fwd_be_rs1_dec(fwd_be_rs1_dec),
    .fwd_be_rs2_dec(fwd_be_rs2_dec),
    .fwd_be_rs1_exe(fwd_be_rs1_exe),
    .fwd_be_rs2_exe(fwd_be_rs2_exe),
    .alu_a_sel_fwd(alu_a_sel_fwd),
    .alu_b_sel_fwd(alu_b_sel_fwd),
    .bc_a_sel_fwd(bc_a_sel_fwd),
    .bcs_b_sel_fwd(bcs_b_sel_fwd),
    .rf_a_sel_fwd(rf_a_sel_fwd),
    .rf_b_sel_fwd(rf_b_sel_fwd),
    .hazard_be(hazard_be)
);

ama_riscv_fwd_data_mux dec_rs1_mux_i (
    .fwd_be(fwd_be_rs1_dec), .mem_wr(mem_wr), .wbk_wr(wbk_wr), .opnd(dec_fwd_rs1)
);

ama_riscv_fwd_data_mux dec_rs2_mux_i (
    .fwd_be(fwd_be_rs2_dec), .mem_wr(mem_wr), .wbk_wr(wbk_wr), .opnd(dec_fwd_rs2)
);

ama_riscv_fwd_data_mux exe_rs1_mux_i (
    .fwd_be(fwd_be_rs1_exe), .mem_wr(mem_wr), .wbk_wr(wbk_wr), .opnd(exe_fwd_rs1)
);

ama_riscv_fwd_data_mux exe_rs2_mux_i (
    .fwd_be(fwd_be_rs2_exe), .mem_wr(mem_wr), .wbk_wr(wbk_wr), .opnd(exe_fwd_rs2)
);

assign dec_rs1_val = rf_a_sel_fwd ? dec_fwd_rs1 : rf_rs1_data;
assign dec_rs2_val = rf_b_sel_fwd ? dec_fwd_rs2 : rf_rs2_data;

ama_riscv_pipe_ctrl pipe_ctrl_i (
    .clk(clk),
    .rst_n(rst_n),
    .dec_in(dec_inst),
    .dec_rs1_val(dec_rs1_val),
    .dec_rs2_val(dec_rs2_val),
    .hazard_be(hazard_be),
    .exe_inst(exe_inst),
    .mem_inst(mem_inst),
    .wbk_inst(wbk_inst),
    .exe_rs1_val(exe_rs1_val),
    .exe_rs2_val(exe_rs2_val)
);

// exe slot is not issued while it waits on a load
always_comb begin
    exe_opnd.valid = exe_inst.valid && !hazard_be.to_exe;
    exe_opnd.rs1_val =
        ((alu_a_sel_fwd == ama_riscv_pkg::ALU_A_SEL_FWD) || bc_a_sel_fwd) ?
        exe_fwd_rs1 : exe_rs1_val;
    exe_opnd.rs2_val =
        ((alu_b_sel_fwd == ama_riscv_pkg::ALU_B_SEL_FWD) || bcs_b_sel_fwd) ?
        exe_fwd_rs2 : exe_rs2_val;
    exe_opnd.alu_a_sel = alu_a_sel_fwd;
    exe_opnd.alu_b_sel = alu_b_sel_fwd;
end

endmodule

// File: tests/ama_riscv_operand_stage_tb.sv
`timescale 1ns/1ps

module ama_riscv_operand_stage_tb;

localparam int RST_CYCLES = 16;
localparam int DRAIN = 4;
localparam int MARGIN = 200;

logic clk;
logic rst_n;
ama_riscv_pkg::inst_ctrl_t dec_inst;
logic dec_stall;
ama_riscv_pkg::exe_opnd_t exe_opnd;
ama_riscv_pkg::stage_wr_t wbk_wr;

// model of the exe, mem and wbk slots and the committed registers
ama_riscv_pkg::inst_ctrl_t m_exe;
ama_riscv_pkg::inst_ctrl_t m_mem;
ama_riscv_pkg::inst_ctrl_t m_wbk;
ama_riscv_pkg::data_t arch [32];
logic dec_taken;
int err_count;
int check_count;
int stall_cycles;

ama_riscv_pkg::inst_ctrl_t stream [$];
logic [31:0] lfsr;
int budget;
int flow_errs;
int cycle_count;

ama_riscv_operand_stage uut (
    .clk(clk),
    .rst_n(rst_n),
    .dec_inst(dec_inst),
    .dec_stall(dec_stall),
    .exe_opnd(exe_opnd),
    .wbk_wr(wbk_wr)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

// galois lfsr stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        r = {r[30:0], lfsr[0]};
    end
    return r;
endfunction

function automatic logic writes(input ama_riscv_pkg::inst_ctrl_t s,
                                input ama_riscv_pkg::rf_addr_t rs);
    return (rs != 5'd0) && s.valid &&
        ((s.rd_we && (s.rd == rs)) || (s.rdp_we && ((s.rd ^ 5'd1) == rs)));
endfunction

// expected source value, youngest in-flight write first
function automatic ama_riscv_pkg::data_t ref_value(input ama_riscv_pkg::rf_addr_t rs);
    if (rs == 5'd0) return '0;
    if (writes(m_mem, rs)) return (m_mem.rd == rs) ? m_mem.result : m_mem.result_p;
    if (writes(m_wbk, rs)) return (m_wbk.rd == rs) ? m_wbk.result : m_wbk.result_p;
    return arch[rs];
endfunction

function automatic ama_riscv_pkg::inst_ctrl_t op(input int rd, input int rs1, input int rs2,
                                                 input logic [31:0] result);
    ama_riscv_pkg::inst_ctrl_t i;
    i = '0;
    i.valid = 1'b1;
    i.rd = 5'(rd);
    i.rs1 = 5'(rs1);
    i.rs2 = 5'(rs2);
    i.rd_we = 1'b1;
    i.alu_a_sel = ama_riscv_pkg::ALU_A_SEL_RS1;
    i.alu_b_sel = ama_riscv_pkg::ALU_B_SEL_RS2;
    i.result = result;
    i.result_p = ~result;
    return i;
endfunction

function automatic ama_riscv_pkg::inst_ctrl_t rand_inst();
    ama_riscv_pkg::inst_ctrl_t i;
    logic [31:0] kind;
    i = '0;
    // roughly one slot in eight is a bubble
    if (rand_bits(3) == 32'd0) return i;
    kind = rand_bits(2);
    i.valid = 1'b1;
    i.rs1 = 5'(rand_bits(3));
    i.rs2 = 5'(rand_bits(3));
    i.rd = 5'(rand_bits(3));
    i.load = (kind == 32'd1);
    i.store = (kind == 32'd2);
    i.branch = (kind == 32'd3);
    i.rd_we = !i.store && !i.branch && (rand_bits(2) != 32'd0);
    i.rdp_we = !i.store && !i.branch && (rand_bits(2) == 32'd0);
    i.alu_a_sel = (rand_bits(1) == 32'd1) ? ama_riscv_pkg::ALU_A_SEL_PC :
        ama_riscv_pkg::ALU_A_SEL_RS1;
    i.alu_b_sel = (rand_bits(1) == 32'd1) ? ama_riscv_pkg::ALU_B_SEL_IMM :
        ama_riscv_pkg::ALU_B_SEL_RS2;
    i.result = rand_bits(32);
    i.result_p = rand_bits(32);
    return i;
endfunction

task automatic fail_check(input string msg);
    $display("[ERROR] t=%0t: %s", $time, msg);
    err_count++;
endtask

task automatic clear_model();
    m_exe = '0;
    m_mem = '0;
    m_wbk = '0;
    for (int i = 0; i < 32; i++) begin
        arch[i] = '0;
    end
    dec_taken = 1'b1;
endtask

task automatic compare_and_step();
    logic haz_exe;
    logic haz_dec;
    logic use_a;
    logic use_b;
    ama_riscv_pkg::alu_a_sel_t exp_a;
    ama_riscv_pkg::alu_b_sel_t exp_b;
    ama_riscv_pkg::rf_addr_t rdp;
    haz_exe = m_mem.valid && m_mem.load &&
        (writes(m_mem, m_exe.rs1) || writes(m_mem, m_exe.rs2));
    haz_dec = m_mem.valid && m_mem.load && dec_inst.valid &&
        (writes(m_mem, dec_inst.rs1) || writes(m_mem, dec_inst.rs2));
    check_count++;
    if (dec_stall !== (haz_exe || haz_dec))
        fail_check($sformatf("dec_stall is %b, expected %b", dec_stall, haz_exe || haz_dec));
    if (exe_opnd.valid !== (m_exe.valid && !haz_exe)) begin
        fail_check($sformatf("exe_opnd.valid is %b, expected %b", exe_opnd.valid,
            m_exe.valid && !haz_exe));
    end else if (exe_opnd.valid) begin
        use_a = (m_exe.alu_a_sel == ama_riscv_pkg::ALU_A_SEL_RS1) || m_exe.branch;
        use_b = (m_exe.alu_b_sel == ama_riscv_pkg::ALU_B_SEL_RS2) || m_exe.branch ||
            m_exe.store;
        exp_a = m_exe.alu_a_sel;
        exp_b = m_exe.alu_b_sel;
        if ((exp_a == ama_riscv_pkg::ALU_A_SEL_RS1) &&
            (writes(m_mem, m_exe.rs1) || writes(m_wbk, m_exe.rs1)))
            exp_a = ama_riscv_pkg::ALU_A_SEL_FWD;
        if ((exp_b == ama_riscv_pkg::ALU_B_SEL_RS2) &&
            (writes(m_mem, m_exe.rs2) || writes(m_wbk, m_exe.rs2)))
            exp_b = ama_riscv_pkg::ALU_B_SEL_FWD;
        if (use_a && (exe_opnd.rs1_val !== ref_value(m_exe.rs1)))
            fail_check($sformatf("x%0d as rs1 is %h, expected %h", m_exe.rs1,
                exe_opnd.rs1_val, ref_value(m_exe.rs1)));
        if (use_b && (exe_opnd.rs2_val !== ref_value(m_exe.rs2)))
            fail_check($sformatf("x%0d as rs2 is %h, expected %h", m_exe.rs2,
                exe_opnd.rs2_val, ref_value(m_exe.rs2)));
        if ((exe_opnd.alu_a_sel !== exp_a) || (exe_opnd.alu_b_sel !== exp_b))
            fail_check($sformatf("selects are %0d/%0d, expected %0d/%0d",
                exe_opnd.alu_a_sel, exe_opnd.alu_b_sel, exp_a, exp_b));
    end
    if ((wbk_wr.rd_we !== (m_wbk.valid && m_wbk.rd_we)) ||
        (wbk_wr.rdp_we !== (m_wbk.valid && m_wbk.rdp_we))) begin
        fail_check($sformatf("wbk enables are %b%b, expected %b%b", wbk_wr.rd_we,
            wbk_wr.rdp_we, m_wbk.valid && m_wbk.rd_we, m_wbk.valid && m_wbk.rdp_we));
    end else if ((wbk_wr.rd_we || wbk_wr.rdp_we) && ((wbk_wr.rd !== m_wbk.rd) ||
        (wbk_wr.rd_we && (wbk_wr.rd_data !== m_wbk.result)) ||
        (wbk_wr.rdp_we && (wbk_wr.rdp_data !== m_wbk.result_p)))) begin
        fail_check($sformatf("wbk write to x%0d is %h/%h, expected x%0d %h/%h", wbk_wr.rd,
            wbk_wr.rd_data, wbk_wr.rdp_data, m_wbk.rd, m_wbk.result, m_wbk.result_p));
    end
    // commit wbk, then move the slots under the stall rules
    rdp = m_wbk.rd ^ 5'd1;
    if (m_wbk.valid && m_wbk.rd_we && (m_wbk.rd != 5'd0)) arch[m_wbk.rd] = m_wbk.result;
    if (m_wbk.valid && m_wbk.rdp_we && (rdp != 5'd0)) arch[rdp] = m_wbk.result_p;
    m_wbk = m_mem;
    if (haz_exe) begin
        m_mem = '0;
        dec_taken = 1'b0;
    end else begin
        m_mem = m_exe;
        m_exe = (haz_dec || !dec_inst.valid) ? '0 : dec_inst;
        dec_taken = !haz_dec;
    end
    if (dec_stall) stall_cycles++;
endtask

always @(posedge clk) begin
    if (!rst_n) begin
        clear_model();
    end else begin
        compare_and_step();
    end
end

// feeds the queued stream on falling edges, holding while dec stalls
task automatic run_test(input string name, input int exp_stalls);
    int errs_before;
    int stalls_before;
    errs_before = err_count + flow_errs;
    stalls_before = stall_cycles;
    for (int i = 0; i < DRAIN; i++) begin
        stream.push_back('0);
    end
    budget = budget + 2 * stream.size();
    foreach (stream[i]) begin
        dec_inst = stream[i];
        @(negedge clk);
        while (!dec_taken) @(negedge clk);
    end
    stream.delete();
    if ((exp_stalls >= 0) && (stall_cycles - stalls_before != exp_stalls)) begin
        $display("[ERROR] t=%0t: %0d stall cycles, expected %0d", $time,
            stall_cycles - stalls_before, exp_stalls);
        flow_errs++;
    end
    $display("test %s done, %0d errors", name, err_count + flow_errs - errs_before);
endtask

initial begin
    ama_riscv_pkg::inst_ctrl_t t;
    rst_n = 1'b0;
    dec_inst = '0;
    lfsr = 32'h77999678;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // reads after reset, writes through wbk, x0 stays zero
    stream.push_back(op(0, 1, 2, 32'h0));
    stream.push_back(op(0, 3, 4, 32'h0));
    stream.push_back(op(1, 0, 0, 32'h1111_0001));
    stream.push_back(op(2, 0, 0, 32'h2222_0002));
    stream.push_back(op(0, 0, 0, 32'hdead_beef));
    stream.push_back(op(3, 0, 1, 32'h3333_0003));
    for (int i = 0; i < DRAIN; i++) stream.push_back('0);
    stream.push_back(op(0, 1, 2, 32'h0));
    stream.push_back(op(0, 0, 3, 32'h0));
    run_test("register file and x0", -1);

    // x5 written twice back to back so the mem copy must win
    stream.push_back(op(5, 0, 0, 32'haaaa_0005));
    stream.push_back(op(5, 0, 0, 32'hbbbb_0005));
    stream.push_back(op(6, 5, 5, 32'h6666_0006));
    stream.push_back(op(0, 5, 6, 32'h0));
    stream.push_back(op(7, 6, 5, 32'h7777_0007));
    stream.push_back('0);
    stream.push_back(op(0, 7, 0, 32'h0));
    run_test("forwarding priority", -1);

    // x4 with x5 as pair read from mem, wbk, dec forward and the register file
    t = op(4, 0, 0, 32'h4444_0004);
    t.rdp_we = 1'b1;
    t.result_p = 32'h5555_0005;
    stream.push_back(t);
    stream.push_back(op(0, 5, 4, 32'h0));
    stream.push_back(op(0, 5, 0, 32'h0));
    stream.push_back(op(0, 0, 5, 32'h0));
    stream.push_back('0);
    stream.push_back(op(0, 5, 5, 32'h0));
    t = op(7, 0, 0, 32'h7777_1007);
    t.rd_we = 1'b0;
    t.rdp_we = 1'b1;
    stream.push_back(t);
    stream.push_back(op(0, 6, 7, 32'h0));
    t = op(1, 0, 0, 32'h1111_1001);
    t.rdp_we = 1'b1;
    stream.push_back(t);
    stream.push_back(op(0, 0, 1, 32'h0));
    t = op(0, 0, 0, 32'h0);
    t.rdp_we = 1'b1;
    t.result_p = 32'h1111_2001;
    stream.push_back(t);
    stream.push_back(op(0, 1, 0, 32'h0));
    run_test("paired registers", -1);

    // the same x6 dependence under each operand source
    stream.push_back(op(6, 0, 0, 32'h6666_1006));
    t = op(0, 6, 6, 32'h0);
    t.alu_a_sel = ama_riscv_pkg::ALU_A_SEL_PC;
    t.alu_b_sel = ama_riscv_pkg::ALU_B_SEL_IMM;
    stream.push_back(t);
    stream.push_back(op(6, 0, 0, 32'h6666_2006));
    t.rd_we = 1'b0;
    t.branch = 1'b1;
    stream.push_back(t);
    t.branch = 1'b0;
    t.store = 1'b1;
    stream.push_back(t);
    stream.push_back(op(6, 0, 0, 32'h6666_3006));
    stream.push_back(op(0, 6, 6, 32'h0));
    run_test("select overrides", -1);

    // loads with dependents at distance one, two and three
    t = op(8, 0, 0, 32'h8888_0008);
    t.load = 1'b1;
    stream.push_back(t);
    stream.push_back(op(0, 8, 0, 32'h0));
    t = op(9, 0, 0, 32'h9999_0009);
    t.load = 1'b1;
    stream.push_back(t);
    stream.push_back(op(10, 1, 2, 32'haaaa_000a));
    stream.push_back(op(0, 0, 9, 32'h0));
    t = op(10, 0, 0, 32'haaaa_100a);
    t.load = 1'b1;
    t.rdp_we = 1'b1;
    stream.push_back(t);
    stream.push_back(op(0, 11, 0, 32'h0));
    t = op(12, 0, 0, 32'hcccc_000c);
    t.load = 1'b1;
    stream.push_back(t);
    stream.push_back(op(0, 1, 1, 32'h0));
    stream.push_back(op(0, 2, 2, 32'h0));
    stream.push_back(op(0, 12, 0, 32'h0));
    run_test("load hazards", 3);

    for (int i = 0; i < 400; i++) stream.push_back(rand_inst());
    run_test("random stream", -1);

    $display("tests: 6, checks: %0d, errors: %0d", check_count, err_count + flow_errs);
    if (err_count + flow_errs == 0) begin
        $display("Simulation PASSED");
    end else begin
        $display("Simulation FAILED");
    end
    $finish;
end

// limit grows with each queued test by two cycles per slot
initial begin
    cycle_count = 0;
    while (cycle_count < RST_CYCLES + budget + MARGIN) begin
        @(posedge clk);
        cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_count);
    $display("Simulation FAILED");
    $finish;
end

endmodule

// File: sources.f
source/ama_riscv_pkg.sv
source/ama_riscv_operand_forwarding.sv
source/ama_riscv_reg_file.sv
source/ama_riscv_fwd_data_mux.sv
source/ama_riscv_pipe_ctrl.sv
source/ama_riscv_operand_stage.sv
tests/ama_riscv_operand_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= ama_riscv_operand_stage_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
